// File: fuse_settings.svh
// Fuse controller build settings
// Partition count, partition depth, fuse word width and the index
// widths carried on the command bus
`ifndef FUSE_SETTINGS_SVH
`define FUSE_SETTINGS_SVH

// Number of fuse partitions in the array
`define FUSE_NUM_PART 4

// Fuse words held by each partition
`define FUSE_PART_WORDS 4

// Width of one fuse word
`define FUSE_WORD_W 32

// Partition index width on the command bus
// Wide enough that out-of-range indices exist once the count shrinks
`define FUSE_PART_AW 2

// Word index width on the command and partition buses
`define FUSE_WORD_AW 2

`endif

// File: fuse_pkg.sv
// Fuse controller shared types
// Life-cycle encodings and decoder, error codes, command and response
// structs, partition bus structs and the partition life-cycle phase table

`include "fuse_settings.svh"

package fuse_pkg;

  // Raw life-cycle codeword, sparse so single faults land in Scrap
  typedef enum logic [15:0] {
    LcStRaw          = 16'h0000,
    LcStTestUnlocked = 16'h3a5c,
    LcStTestLocked   = 16'h5c93,
    LcStDev          = 16'h96e1,
    LcStProd         = 16'ha71e,
    LcStProdEnd      = 16'hc3b4,
    LcStRma          = 16'he94b
  } lc_state_e;

  // Decoded state, ordered so that later phases compare greater
  typedef enum logic [2:0] {
    DecLcStRaw          = 3'd0,
    DecLcStTestUnlocked = 3'd1,
    DecLcStTestLocked   = 3'd2,
    DecLcStDev          = 3'd3,
    DecLcStProd         = 3'd4,
    DecLcStProdEnd      = 3'd5,
    DecLcStRma          = 3'd6,
    DecLcStScrap        = 3'd7
  } dec_lc_state_e;

  typedef enum logic [1:0] {
    NoError       = 2'd0,
    AccessError   = 2'd1,
    LockError     = 2'd2,
    FsmStateError = 2'd3
  } fuse_err_e;

  typedef logic [`FUSE_WORD_W-1:0] fuse_word_t;

  // Contents of one partition, word 0 lowest
  typedef fuse_word_t [`FUSE_PART_WORDS-1:0] fuse_part_words_t;

  // Whole array, partition 0 word 0 lowest
  typedef fuse_part_words_t [`FUSE_NUM_PART-1:0] fuse_bcast_t;

  // DAI command
  typedef struct packed {
    logic                     write;
    logic [`FUSE_PART_AW-1:0] part;
    logic [`FUSE_WORD_AW-1:0] word;
    fuse_word_t               data;
  } fuse_cmd_t;

  // DAI response
  typedef struct packed {
    fuse_word_t data;
    fuse_err_e  err;
  } fuse_rsp_t;

  // DAI to partition request, strobe high for one cycle
  typedef struct packed {
    logic                     strobe;
    logic                     write;
    logic [`FUSE_WORD_AW-1:0] word;
    fuse_word_t               data;
  } fuse_part_req_t;

  // Partition reply, valid the cycle after the strobe
  typedef struct packed {
    fuse_word_t data;
    logic       lock_err;
  } fuse_part_rsp_t;

  // Any codeword outside the named set is treated as Scrap
  function automatic dec_lc_state_e decode_lc_state(lc_state_e lc_state);
    case (lc_state)
      LcStRaw:          return DecLcStRaw;
      LcStTestUnlocked: return DecLcStTestUnlocked;
      LcStTestLocked:   return DecLcStTestLocked;
      LcStDev:          return DecLcStDev;
      LcStProd:         return DecLcStProd;
      LcStProdEnd:      return DecLcStProdEnd;
      LcStRma:          return DecLcStRma;
      default:          return DecLcStScrap;
    endcase
  endfunction

  // Last decoded state in which partition idx still takes writes
  function automatic dec_lc_state_e part_lc_phase(int unsigned idx);
    case (idx)
      0:       return DecLcStTestUnlocked;
      1:       return DecLcStDev;
      2:       return DecLcStProd;
      default: return DecLcStRma;
    endcase
  endfunction

endpackage

// File: fuse_skid_buf.sv
// Two-entry valid/ready skid buffer
// Registers the full path so ready on one side never depends on the
// other side, payload type set by parameter
`timescale 1ns/1ps

module fuse_skid_buf #(
  parameter type T_PAYLOAD = logic
) (
  input  logic     core_clk,
  input  logic     rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  T_PAYLOAD in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output T_PAYLOAD out_data
);

  T_PAYLOAD   mem_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       push;
  logic       pop;

  // Ready while an entry is free, valid while one is filled
  assign in_ready  = (count_q != 2'd2);
  assign out_valid = (count_q != 2'd0);
  assign out_data  = mem_q[rd_ptr_q];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // Entry storage
  always_ff @(posedge core_clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data;
    end
  end

  always_ff @(posedge core_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      // Occupancy only moves when exactly one side transfers
      case ({push, pop})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// File: fuse_partition.sv
// One fuse partition
// Holds its words with set-only writes, and refuses writes once the
// decoded life-cycle state has moved past the partition's phase
`timescale 1ns/1ps

module fuse_partition #(
  parameter fuse_pkg::dec_lc_state_e LC_PHASE = fuse_pkg::DecLcStRma
) (
  input  logic                       core_clk,
  input  logic                       rst_n,
  input  fuse_pkg::lc_state_e        lc_state,
  input  fuse_pkg::fuse_part_req_t   req,
  output fuse_pkg::fuse_part_rsp_t   rsp,
  output fuse_pkg::fuse_part_words_t words
);

  fuse_pkg::dec_lc_state_e    dec_state;
  fuse_pkg::fuse_part_words_t words_q;
  fuse_pkg::fuse_part_rsp_t   rsp_q;
  fuse_pkg::fuse_word_t       cur_word;
  fuse_pkg::fuse_word_t       set_word;
  logic                       locked;
  logic                       do_write;

  // Write lock from this partition's own decode
  assign dec_state = fuse_pkg::decode_lc_state(lc_state);
  assign locked    = (dec_state > LC_PHASE);

  assign cur_word = words_q[req.word];
  // Fuses only blow, so a write ORs into the stored word
  assign set_word = cur_word | req.data;
  assign do_write = req.strobe && req.write && !locked;

  // Fuse storage, blank after reset
  always_ff @(posedge core_clk or negedge rst_n) begin
    if (!rst_n) begin
      words_q <= '0;
    end else if (do_write) begin
      words_q[req.word] <= set_word;
    end
  end

  // Reply one cycle after the strobe
  // Write replies carry the word as it ends up, locked writes the old word
  always_ff @(posedge core_clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_q <= '0;
    end else if (req.strobe) begin
      rsp_q.lock_err <= req.write && locked;
      rsp_q.data     <= do_write ? set_word : cur_word;
    end
  end

  assign rsp   = rsp_q;
  assign words = words_q;

endmodule

// File: fuse_broadcast.sv
// Fuse broadcast collector
// Registers every partition's words into one flat output, and clears it
// while zeroize is held or the life-cycle state decodes to Scrap
`timescale 1ns/1ps

`include "fuse_settings.svh"

module fuse_broadcast (
  input  logic                                            core_clk,
  input  logic                                            rst_n,
  input  fuse_pkg::fuse_part_words_t [`FUSE_NUM_PART-1:0] part_words,
  input  fuse_pkg::lc_state_e                             lc_state,
  input  logic                                            zeroize,
  output fuse_pkg::fuse_bcast_t                           bcast
);

  fuse_pkg::dec_lc_state_e dec_state;
  fuse_pkg::fuse_bcast_t   bcast_d;
  fuse_pkg::fuse_bcast_t   bcast_q;
  logic                    clear;

  assign dec_state = fuse_pkg::decode_lc_state(lc_state);
  assign clear     = zeroize || (dec_state == fuse_pkg::DecLcStScrap);

  // Partition 0 lands in the lowest slice
  always_comb begin
    bcast_d = '0;
    if (!clear) begin
      for (int i = 0; i < `FUSE_NUM_PART; i++) begin
        bcast_d[i] = part_words[i];
      end
    end
  end

  always_ff @(posedge core_clk or negedge rst_n) begin
    if (!rst_n) begin
      bcast_q <= '0;
    end else begin
      bcast_q <= bcast_d;
    end
  end

  assign bcast = bcast_q;

endmodule

// File: fuse_dai.sv
// Fuse direct-access interface sequencer
// Takes one command at a time, filters range and life-cycle state,
// strobes the addressed partition and returns its reply as a response.
// Escalation latches a terminal error state until reset
`timescale 1ns/1ps

`include "fuse_settings.svh"

module fuse_dai (
  input  logic                                          core_clk,
  input  logic                                          rst_n,
  input  logic                                          cmd_valid,
  output logic                                          cmd_ready,
  input  fuse_pkg::fuse_cmd_t                           cmd,
  input  fuse_pkg::lc_state_e                           lc_state,
  input  logic                                          escalate,
  output fuse_pkg::fuse_part_req_t [`FUSE_NUM_PART-1:0] part_req,
  input  fuse_pkg::fuse_part_rsp_t [`FUSE_NUM_PART-1:0] part_rsp,
  output logic                                          rsp_valid,
  input  logic                                          rsp_ready,
  output fuse_pkg::fuse_rsp_t                           rsp
);

  typedef enum logic [2:0] {
    Idle     = 3'd0,
    Dispatch = 3'd1,
    Wait     = 3'd2,
    Respond  = 3'd3,
    ErrorSt  = 3'd4
  } dai_state_e;

  dai_state_e              state_q;
  fuse_pkg::fuse_cmd_t     cmd_q;
  fuse_pkg::fuse_err_e     err_q;
  fuse_pkg::fuse_rsp_t     rsp_q;
  fuse_pkg::dec_lc_state_e dec_state;
  logic                    esc_q;
  logic [1:0]              err_phase_q;
  logic                    in_range;
  logic                    cmd_accept;

  assign dec_state = fuse_pkg::decode_lc_state(lc_state);

  // Range filter against the configured array size
  assign in_range = (int'(cmd.part) < `FUSE_NUM_PART) &&
                    (int'(cmd.word) < `FUSE_PART_WORDS);

  // In ErrorSt phase 0 takes a command, phases 1 and 2 mirror Dispatch and Wait
  assign cmd_ready = (state_q == Idle) || (state_q == ErrorSt && err_phase_q == 2'd0);
  assign cmd_accept = cmd_valid && cmd_ready;

  assign rsp_valid = (state_q == Respond) || (state_q == ErrorSt && err_phase_q == 2'd3);
  assign rsp       = rsp_q;

  // Only the addressed partition sees a strobe, and only for clean commands
  always_comb begin
    for (int i = 0; i < `FUSE_NUM_PART; i++) begin
      part_req[i].strobe = (state_q == Dispatch) && (err_q == fuse_pkg::NoError) &&
                           !esc_q && (int'(cmd_q.part) == i);
      part_req[i].write  = cmd_q.write;
      part_req[i].word   = cmd_q.word;
      part_req[i].data   = cmd_q.data;
    end
  end

  // Command and error code captured at accept
  always_ff @(posedge core_clk) begin
    if (state_q == Idle && cmd_accept) begin
      cmd_q <= cmd;
      if (dec_state == fuse_pkg::DecLcStScrap) begin
        err_q <= fuse_pkg::FsmStateError;
      end else if (!in_range) begin
        err_q <= fuse_pkg::AccessError;
      end else begin
        err_q <= fuse_pkg::NoError;
      end
    end
  end

  always_ff @(posedge core_clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= Idle;
      esc_q       <= 1'b0;
      err_phase_q <= 2'd0;
      rsp_q       <= '0;
    end else begin
      esc_q <= escalate;
      if (esc_q && state_q != ErrorSt) begin
        state_q <= ErrorSt;
        // Any command already taken still gets exactly one response
        case (state_q)
          Idle: err_phase_q <= cmd_accept ? 2'd1 : 2'd0;
          Respond: err_phase_q <= rsp_ready ? 2'd0 : 2'd3;
          default: begin
            err_phase_q <= 2'd3;
            rsp_q.data  <= '0;
            rsp_q.err   <= fuse_pkg::FsmStateError;
          end
        endcase
      end else begin
        case (state_q)
          Idle: begin
            if (cmd_accept) begin
              state_q <= Dispatch;
            end
          end
          Dispatch: state_q <= Wait;
          Wait: begin
            // Partition reply is valid in this cycle
            if (err_q == fuse_pkg::NoError) begin
              rsp_q.data <= part_rsp[cmd_q.part].data;
              rsp_q.err  <= part_rsp[cmd_q.part].lock_err ? fuse_pkg::LockError
                                                           : fuse_pkg::NoError;
            end else begin
              rsp_q.data <= '0;
              rsp_q.err  <= err_q;
            end
            state_q <= Respond;
          end
          Respond: begin
            if (rsp_ready) begin
              state_q <= Idle;
            end
          end
          ErrorSt: begin
            // Terminal, every command answered with FsmStateError
            case (err_phase_q)
              2'd0: err_phase_q <= cmd_accept ? 2'd1 : 2'd0;
              2'd1: err_phase_q <= 2'd2;
              2'd2: begin
                err_phase_q <= 2'd3;
                rsp_q.data  <= '0;
                rsp_q.err   <= fuse_pkg::FsmStateError;
              end
              default: err_phase_q <= rsp_ready ? 2'd0 : 2'd3;
            endcase
          end
          default: state_q <= ErrorSt;
        endcase
      end
    end
  end

endmodule

// File: fuse_ctrl_top.sv
// Fuse controller top level
// Command and response skid buffers around the DAI, one partition per
// slot built in a loop, and the broadcast collector over all of them
`timescale 1ns/1ps

`include "fuse_settings.svh"

module fuse_ctrl_top (
  input  logic                  core_clk,
  input  logic                  rst_n,
  input  logic                  cmd_valid,
  output logic                  cmd_ready,
  input  fuse_pkg::fuse_cmd_t   cmd,
  output logic                  rsp_valid,
  input  logic                  rsp_ready,
  output fuse_pkg::fuse_rsp_t   rsp,
  input  fuse_pkg::lc_state_e   lc_state,
  input  logic                  escalate,
  input  logic                  zeroize,
  output fuse_pkg::fuse_bcast_t bcast
);

  // Skid buffer to DAI
  logic                dai_cmd_valid;
  logic                dai_cmd_ready;
  fuse_pkg::fuse_cmd_t dai_cmd;

  // DAI to skid buffer
  logic                dai_rsp_valid;
  logic                dai_rsp_ready;
  fuse_pkg::fuse_rsp_t dai_rsp;

  // Partition buses
  fuse_pkg::fuse_part_req_t   [`FUSE_NUM_PART-1:0] part_req;
  fuse_pkg::fuse_part_rsp_t   [`FUSE_NUM_PART-1:0] part_rsp;
  fuse_pkg::fuse_part_words_t [`FUSE_NUM_PART-1:0] part_words;

  fuse_skid_buf #(
    .T_PAYLOAD(fuse_pkg::fuse_cmd_t)
  ) i_cmd_skid_buf (
    .core_clk (core_clk),
    .rst_n    (rst_n),
    .in_valid (cmd_valid),
    .in_ready (cmd_ready),
    .in_data  (cmd),
    .out_valid(dai_cmd_valid),
    .out_ready(dai_cmd_ready),
    .out_data (dai_cmd)
  );

  fuse_dai i_fuse_dai (
    .core_clk (core_clk),
    .rst_n    (rst_n),
    .cmd_valid(dai_cmd_valid),
    .cmd_ready(dai_cmd_ready),
    .cmd      (dai_cmd),
    .lc_state (lc_state),
    .escalate (escalate),
    .part_req (part_req),
    .part_rsp (part_rsp),
    .rsp_valid(dai_rsp_valid),
    .rsp_ready(dai_rsp_ready),
    .rsp      (dai_rsp)
  );

  fuse_skid_buf #(
    .T_PAYLOAD(fuse_pkg::fuse_rsp_t)
  ) i_rsp_skid_buf (
    .core_clk (core_clk),
    .rst_n    (rst_n),
    .in_valid (dai_rsp_valid),
    .in_ready (dai_rsp_ready),
    .in_data  (dai_rsp),
    .out_valid(rsp_valid),
    .out_ready(rsp_ready),
    .out_data (rsp)
  );

  // Write-lock phase per slot from the package table
  for (genvar i = 0; i < `FUSE_NUM_PART; i++) begin : g_part
    fuse_partition #(
      .LC_PHASE(fuse_pkg::part_lc_phase(i))
    ) i_fuse_partition (
      .core_clk(core_clk),
      .rst_n   (rst_n),
      .lc_state(lc_state),
      .req     (part_req[i]),
      .rsp     (part_rsp[i]),
      .words   (part_words[i])
    );
  end

  fuse_broadcast i_fuse_broadcast (
    .core_clk  (core_clk),
    .rst_n     (rst_n),
    .part_words(part_words),
    .lc_state  (lc_state),
    .zeroize   (zeroize),
    .bcast     (bcast)
  );

endmodule

// File: tb_fuse_ctrl.sv
// Fuse controller testbench
// Drives DAI commands against a fuse array model with random response
// stalls, and checks responses, the hold rule and the broadcast output
`timescale 1ns/1ps

`include "fuse_settings.svh"

module tb_fuse_ctrl;

  localparam int CMD_LIMIT   = 200;
  localparam int DRAIN_LIMIT = 4000;

  logic                  core_clk;
  logic                  rst_n;
  logic                  cmd_valid;
  logic                  cmd_ready;
  fuse_pkg::fuse_cmd_t   cmd;
  logic                  rsp_valid;
  logic                  rsp_ready;
  fuse_pkg::fuse_rsp_t   rsp;
  fuse_pkg::lc_state_e   lc_state;
  logic                  escalate;
  logic                  zeroize;
  fuse_pkg::fuse_bcast_t bcast;

  // Reference fuse array and expected responses in command order
  fuse_pkg::fuse_word_t model [`FUSE_NUM_PART][`FUSE_PART_WORDS];
  fuse_pkg::fuse_rsp_t  exp_q [$];
  fuse_pkg::fuse_rsp_t  rsp_prev;
  logic                 escalated;
  logic                 hold_q;
  logic                 clear_q;
  integer               seed = 32'h3fca6851;
  int                   fail_cnt;
  int                   timeout_cnt;
  int                   rsp_cnt;

  fuse_ctrl_top i_fuse_ctrl_top (
    .core_clk (core_clk),
    .rst_n    (rst_n),
    .cmd_valid(cmd_valid),
    .cmd_ready(cmd_ready),
    .cmd      (cmd),
    .rsp_valid(rsp_valid),
    .rsp_ready(rsp_ready),
    .rsp      (rsp),
    .lc_state (lc_state),
    .escalate (escalate),
    .zeroize  (zeroize),
    .bcast    (bcast)
  );

  initial begin
    core_clk = 1'b0;
    forever #2 core_clk = ~core_clk;
  end

  // Life-cycle order, 7 for any unnamed codeword
  function automatic int lc_rank(fuse_pkg::lc_state_e s);
    case (s)
      fuse_pkg::LcStRaw:          return 0;
      fuse_pkg::LcStTestUnlocked: return 1;
      fuse_pkg::LcStTestLocked:   return 2;
      fuse_pkg::LcStDev:          return 3;
      fuse_pkg::LcStProd:         return 4;
      fuse_pkg::LcStProdEnd:      return 5;
      fuse_pkg::LcStRma:          return 6;
      default:                    return 7;
    endcase
  endfunction

  // Highest rank in which a partition still takes writes
  function automatic int last_writable(int p);
    case (p)
      0:       return 1;
      1:       return 3;
      2:       return 4;
      default: return 6;
    endcase
  endfunction

  // Applies one command to the model and returns its response
  function automatic fuse_pkg::fuse_rsp_t expect_rsp(fuse_pkg::fuse_cmd_t c);
    fuse_pkg::fuse_rsp_t r;
    int p;
    int w;
    p = int'(c.part);
    w = int'(c.word);
    r = '{data: '0, err: fuse_pkg::NoError};
    if (escalated || lc_rank(lc_state) == 7) begin
      r.err = fuse_pkg::FsmStateError;
    end else if (p >= `FUSE_NUM_PART || w >= `FUSE_PART_WORDS) begin
      r.err = fuse_pkg::AccessError;
    end else if (c.write && lc_rank(lc_state) > last_writable(p)) begin
      r.err  = fuse_pkg::LockError;
      r.data = model[p][w];
    end else begin
      // Writes only set bits, the reply shows the resulting word
      if (c.write) begin
        model[p][w] = model[p][w] | c.data;
      end
      r.data = model[p][w];
    end
    return r;
  endfunction

  task automatic finish_run();
    $display("Errors: mismatches=%0d timeouts=%0d responses=%0d", fail_cnt, timeout_cnt,
             rsp_cnt);
    if (fail_cnt == 0 && timeout_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  task automatic send_cmd(input logic wr, input logic [`FUSE_PART_AW-1:0] p,
                          input logic [`FUSE_WORD_AW-1:0] w, input fuse_pkg::fuse_word_t d);
    int cycles;
    cycles = 0;
    @(negedge core_clk);
    cmd_valid = 1'b1;
    cmd       = '{write: wr, part: p, word: w, data: d};
    @(posedge core_clk);
    while (!cmd_ready) begin
      cycles++;
      if (cycles > CMD_LIMIT) begin
        timeout_cnt++;
        $display("Timeout at %0t: command was never accepted", $time);
        finish_run();
      end
      @(posedge core_clk);
    end
    exp_q.push_back(expect_rsp(cmd));
  endtask

  // Stops commands and waits for every outstanding response
  task automatic wait_drain();
    int cycles;
    cycles = 0;
    @(negedge core_clk);
    cmd_valid = 1'b0;
    while (exp_q.size() != 0) begin
      cycles++;
      if (cycles > DRAIN_LIMIT) begin
        timeout_cnt++;
        $display("Timeout at %0t: %0d responses never arrived", $time, exp_q.size());
        finish_run();
      end
      @(posedge core_clk);
    end
    repeat (2) @(posedge core_clk);
  endtask

  task automatic check_bcast();
    fuse_pkg::fuse_bcast_t exp;
    exp = '0;
    if (!zeroize && lc_rank(lc_state) != 7) begin
      for (int p = 0; p < `FUSE_NUM_PART; p++) begin
        for (int w = 0; w < `FUSE_PART_WORDS; w++) begin
          exp[p][w] = model[p][w];
        end
      end
    end
    @(negedge core_clk);
    assert (bcast == exp) else begin
      fail_cnt++;
      $display("Fail %0t bcast exp=%h got=%h", $time, exp, bcast);
    end
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (2) @(negedge core_clk);
    rst_n = 1'b1;
    escalated = 1'b0;
    for (int p = 0; p < `FUSE_NUM_PART; p++) begin
      for (int w = 0; w < `FUSE_PART_WORDS; w++) begin
        model[p][w] = '0;
      end
    end
  endtask

  // Responses in order, none without a command
  always @(posedge core_clk) begin
    fuse_pkg::fuse_rsp_t exp;
    if (rst_n && rsp_valid && rsp_ready) begin
      if (exp_q.size() == 0) begin
        fail_cnt++;
        $display("Response at %0t arrived with no command outstanding", $time);
      end else begin
        exp = exp_q.pop_front();
        rsp_cnt++;
        assert (rsp == exp) else begin
          fail_cnt++;
          $display("Fail %0t rsp exp=%h got=%h", $time, exp, rsp);
        end
      end
    end
  end

  // A stalled response keeps valid and data until taken
  always @(posedge core_clk) begin
    if (!rst_n) begin
      hold_q <= 1'b0;
    end else begin
      if (hold_q) begin
        assert (rsp_valid) else begin
          fail_cnt++;
          $display("rsp_valid dropped at %0t before the response was taken", $time);
        end
        assert (rsp == rsp_prev) else begin
          fail_cnt++;
          $display("Fail %0t rsp exp=%h got=%h", $time, rsp_prev, rsp);
        end
      end
      hold_q   <= rsp_valid && !rsp_ready;
      rsp_prev <= rsp;
    end
  end

  // Zeroize or Scrap at one edge clears bcast at the next
  always @(posedge core_clk) begin
    if (!rst_n) begin
      clear_q <= 1'b0;
    end else begin
      if (clear_q) begin
        assert (bcast == '0) else begin
          fail_cnt++;
          $display("Fail %0t bcast exp=0 got=%h", $time, bcast);
        end
      end
      clear_q <= zeroize || (lc_rank(lc_state) == 7);
    end
  end

  // Random back-pressure on the response side
  always @(negedge core_clk) begin
    rsp_ready = (($random(seed) & 3) != 0);
  end

  initial begin
    rst_n       = 1'b0;
    cmd_valid   = 1'b0;
    cmd         = '0;
    rsp_ready   = 1'b0;
    lc_state    = fuse_pkg::LcStRaw;
    escalate    = 1'b0;
    zeroize     = 1'b0;
    fail_cnt    = 0;
    timeout_cnt = 0;
    rsp_cnt     = 0;
    apply_reset();
    assert (cmd_ready) else begin
      fail_cnt++;
      $display("cmd_ready stayed low after reset");
    end

    // Raw, two writes per word then a read of each word
    for (int p = 0; p < `FUSE_NUM_PART; p++) begin
      for (int w = 0; w < `FUSE_PART_WORDS; w++) begin
        send_cmd(1'b1, p[`FUSE_PART_AW-1:0], w[`FUSE_WORD_AW-1:0], $random(seed));
        send_cmd(1'b1, p[`FUSE_PART_AW-1:0], w[`FUSE_WORD_AW-1:0], $random(seed));
        send_cmd(1'b0, p[`FUSE_PART_AW-1:0], w[`FUSE_WORD_AW-1:0], '0);
      end
    end
    wait_drain();
    check_bcast();

    // Write lock in Prod, then in Rma
    lc_state = fuse_pkg::LcStProd;
    for (int round = 0; round < 2; round++) begin
      for (int p = 0; p < `FUSE_NUM_PART; p++) begin
        send_cmd(1'b1, p[`FUSE_PART_AW-1:0], 1, $random(seed));
        send_cmd(1'b0, p[`FUSE_PART_AW-1:0], 1, '0);
      end
      wait_drain();
      check_bcast();
      lc_state = fuse_pkg::LcStRma;
    end

    // Every index outside the configured array
    lc_state = fuse_pkg::LcStRaw;
    for (int p = 0; p < (1 << `FUSE_PART_AW); p++) begin
      for (int w = 0; w < (1 << `FUSE_WORD_AW); w++) begin
        if (p >= `FUSE_NUM_PART || w >= `FUSE_PART_WORDS) begin
          send_cmd(1'b1, p[`FUSE_PART_AW-1:0], w[`FUSE_WORD_AW-1:0], $random(seed));
        end
      end
    end
    wait_drain();
    check_bcast();

    // Zeroize pulse, then an unnamed codeword
    zeroize = 1'b1;
    repeat (3) @(negedge core_clk);
    check_bcast();
    zeroize = 1'b0;
    repeat (2) @(negedge core_clk);
    check_bcast();
    lc_state = fuse_pkg::lc_state_e'(16'h1234);
    send_cmd(1'b1, 2, 0, 32'hffff_ffff);
    send_cmd(1'b0, 0, 0, '0);
    wait_drain();
    check_bcast();
    lc_state = fuse_pkg::LcStRaw;
    repeat (2) @(negedge core_clk);
    check_bcast();

    // Escalation is terminal until reset
    escalate  = 1'b1;
    escalated = 1'b1;
    @(negedge core_clk);
    escalate = 1'b0;
    for (int i = 0; i < 6; i++) begin
      send_cmd(i[0], i[`FUSE_PART_AW-1:0], 0, $random(seed));
    end
    wait_drain();
    check_bcast();
    apply_reset();
    send_cmd(1'b0, 0, 0, '0);
    wait_drain();
    check_bcast();

    finish_run();
  end

endmodule

// File: verilog.f
+incdir+.
fuse_pkg.sv
fuse_skid_buf.sv
fuse_partition.sv
fuse_broadcast.sv
fuse_dai.sv
fuse_ctrl_top.sv
tb_fuse_ctrl.sv
